//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl (
    input  wire                      clk,
    input  wire                      proc_reset,
    // processor
    input  wire                      proc_read_i,
    input  icache_pkg::word_addr_t   proc_addr_i,
    output logic                     proc_stall_o,
    output icache_pkg::word_t        proc_rdata_o,
    // memory
    output logic                     mem_read_o,
    output icache_pkg::block_addr_t  mem_addr_o,
    input  icache_pkg::block_t       mem_rdata_i,
    input  wire                      mem_ready_i,
    // ways
    output icache_pkg::word_addr_t   lookup_addr_o,
    input  wire                      way0_hit_i,
    input  wire                      way1_hit_i,
    input  icache_pkg::block_t       way0_block_i,
    input  icache_pkg::block_t       way1_block_i,
    output logic                     way0_fill_o,
    output logic                     way1_fill_o,
    output icache_pkg::block_t       fill_block_o
);

    icache_pkg::ctrl_state_e state_r, state_w;
    icache_pkg::word_addr_t  miss_addr_r;        // held for the whole fetch
    logic [`ICACHE_LINES-1:0] lru_r, lru_w;     // way to replace at each index

    icache_pkg::index_t  lookup_index;
    icache_pkg::offset_t lookup_offset;

    logic [`ICACHE_WAYS-1:0] way_hit;
    icache_pkg::block_t      way_block [`ICACHE_WAYS];
    icache_pkg::block_t      hit_block;

    logic idle;
    logic any_hit;
    logic read_hit;    // served this cycle
    logic read_miss;   // starts a fetch
    logic fill_done;   // block arrives, chosen way written

    // lookup follows the processor while idle, the miss address while fetching
    assign idle          = (state_r == icache_pkg::S_IDLE);
    assign lookup_addr_o = idle ? proc_addr_i : miss_addr_r;
    assign lookup_index  = lookup_addr_o[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign lookup_offset = lookup_addr_o[`ICACHE_OFFSET_W-1:0];

    assign way_hit      = {way1_hit_i, way0_hit_i};
    assign way_block[0] = way0_block_i;
    assign way_block[1] = way1_block_i;

    assign any_hit   = |way_hit;
    assign read_hit  = idle && proc_read_i && any_hit;
    assign read_miss = idle && proc_read_i && !any_hit;
    assign fill_done = (state_r == icache_pkg::S_FETCH) && mem_ready_i;

    // processor side
    assign proc_stall_o = proc_read_i && !(idle && any_hit);

    // and-or merge as at most one way hits
    always_comb begin
        hit_block = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_block = hit_block | way_block[w];
            end
        end
    end

    assign proc_rdata_o = hit_block[lookup_offset*`ICACHE_WORD_W +: `ICACHE_WORD_W];

    // memory request drops in the ready cycle
    assign mem_read_o = read_miss || ((state_r == icache_pkg::S_FETCH) && !mem_ready_i);
    assign mem_addr_o = lookup_addr_o[`ICACHE_ADDR_W-1 -: `ICACHE_BLOCK_ADDR_W];

    // fill goes to the way the lru bit names
    assign way0_fill_o  = fill_done && !lru_r[lookup_index];
    assign way1_fill_o  = fill_done && lru_r[lookup_index];
    assign fill_block_o = mem_rdata_i;

    // next state
    always_comb begin
        state_w = state_r;
        case (state_r)
            icache_pkg::S_IDLE: begin
                if (read_miss) begin
                    state_w = icache_pkg::S_FETCH;
                end
            end
            icache_pkg::S_FETCH: begin
                if (mem_ready_i) begin
                    state_w = icache_pkg::S_IDLE; // lookup hits next cycle
                end
            end
            default: state_w = icache_pkg::S_IDLE;
        endcase
    end

    // lru points at the way not just used
    always_comb begin
        lru_w = lru_r;
        if (read_hit) begin
            lru_w[lookup_index] = way_hit[0]; // hit in way 0 -> replace way 1
        end else if (fill_done) begin
            lru_w[lookup_index] = !lru_r[lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_r <= icache_pkg::S_IDLE;
            lru_r   <= '0;
        end else begin
            state_r <= state_w;
            lru_r   <= lru_w;
        end
    end

    always_ff @(posedge clk) begin
        if (read_miss) begin
            miss_addr_r <= proc_addr_i;
        end
    end

    // a block lives in at most one way
    single_way_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(way0_hit_i && way1_hit_i)
    ) else $error("both ways hit the same address");

    // request held steady until the memory answers
    mem_req_stable: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_read_o && !mem_ready_i) |=> ((mem_read_o || mem_ready_i) && $stable(mem_addr_o))
    ) else $error("memory request changed before mem_ready_i");

endmodule

`default_nettype wire

//--- icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// processor side
`define ICACHE_ADDR_W       30  // word address
`define ICACHE_WORD_W       32

// memory side
`define ICACHE_BLOCK_ADDR_W 28  // tag followed by index
`define ICACHE_BLOCK_W      128 // four words per block

// address split from the top bit down into tag, index and offset
`define ICACHE_TAG_W        26
`define ICACHE_INDEX_W      2
`define ICACHE_OFFSET_W     2   // word within a block

// organisation
`define ICACHE_LINES        4   // lines per way
`define ICACHE_WAYS         2   // one lru bit per index only covers two

`endif

//--- icache_pkg.sv
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]       word_addr_t;  // processor word address
    typedef logic [`ICACHE_BLOCK_ADDR_W-1:0] block_addr_t; // memory block address
    typedef logic [`ICACHE_TAG_W-1:0]        tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]      index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0]     offset_t;
    typedef logic [`ICACHE_WORD_W-1:0]       word_t;
    typedef logic [`ICACHE_BLOCK_W-1:0]      block_t;

    // miss handling
    typedef enum logic {
        S_IDLE,  // lookups from the processor address
        S_FETCH  // waiting on the memory block
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                      clk,
    input  wire                      proc_reset,
    // processor
    input  wire                      proc_read_i,
    input  icache_pkg::word_addr_t   proc_addr_i,
    output logic                     proc_stall_o,
    output icache_pkg::word_t        proc_rdata_o,
    // memory
    output logic                     mem_read_o,
    output icache_pkg::block_addr_t  mem_addr_o,
    input  icache_pkg::block_t       mem_rdata_i,
    input  wire                      mem_ready_i
);

    icache_pkg::word_addr_t lookup_addr;
    icache_pkg::block_t     fill_block;
    logic                   way0_hit, way1_hit;
    icache_pkg::block_t     way0_block, way1_block;
    logic                   way0_fill, way1_fill;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .proc_read_i   (proc_read_i),
        .proc_addr_i   (proc_addr_i),
        .proc_stall_o  (proc_stall_o),
        .proc_rdata_o  (proc_rdata_o),
        .mem_read_o    (mem_read_o),
        .mem_addr_o    (mem_addr_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ready_i   (mem_ready_i),
        .lookup_addr_o (lookup_addr),
        .way0_hit_i    (way0_hit),
        .way1_hit_i    (way1_hit),
        .way0_block_i  (way0_block),
        .way1_block_i  (way1_block),
        .way0_fill_o   (way0_fill),
        .way1_fill_o   (way1_fill),
        .fill_block_o  (fill_block)
    );

    icache_way u_way0 (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .lookup_addr_i (lookup_addr),
        .fill_i        (way0_fill),
        .fill_block_i  (fill_block),
        .hit_o         (way0_hit),
        .block_o       (way0_block)
    );

    icache_way u_way1 (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .lookup_addr_i (lookup_addr),
        .fill_i        (way1_fill),
        .fill_block_i  (fill_block),
        .hit_o         (way1_hit),
        .block_o       (way1_block)
    );

endmodule

`default_nettype wire

//--- icache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module icache_way (
    input  wire                 clk,
    input  wire                 proc_reset,
    input  icache_pkg::word_addr_t lookup_addr_i,
    input  wire                 fill_i,
    input  icache_pkg::block_t  fill_block_i,
    output logic                hit_o,
    output icache_pkg::block_t  block_o
);

    // tag and index of the lookup address
    icache_pkg::tag_t   lookup_tag;
    icache_pkg::index_t lookup_index;

    // line storage
    logic [`ICACHE_LINES-1:0] valid_r;
    icache_pkg::tag_t         tag_r   [`ICACHE_LINES];
    icache_pkg::block_t       block_r [`ICACHE_LINES];

    assign lookup_tag   = lookup_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign lookup_index = lookup_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // tag compare at the addressed line
    assign hit_o   = valid_r[lookup_index] && (tag_r[lookup_index] == lookup_tag);
    assign block_o = block_r[lookup_index];

    // valid bits come up cleared
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_r <= '0;
        end else if (fill_i) begin
            valid_r[lookup_index] <= 1'b1;
        end
    end

    // tag and block written on a fill
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_r[lookup_index]   <= lookup_tag;
            block_r[lookup_index] <= fill_block_i;
        end
    end

    // a fill returns the controller to idle and the next cycle is a lookup
    fill_single_cycle: assert property (
        @(posedge clk) disable iff (proc_reset)
        fill_i |=> !fill_i
    ) else $error("way fill held for two cycles");

    // refill of an already resident tag would leave a duplicate in the other way
    fill_only_on_miss: assert property (
        @(posedge clk) disable iff (proc_reset)
        fill_i |-> !hit_o
    ) else $error("way fill of a line that already hits");

endmodule

`default_nettype wire

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module tb_icache;

    localparam int WAIT_LIMIT   = 20; // well above the longest memory latency
    localparam int RANDOM_READS = 200;
    localparam icache_pkg::word_addr_t RANDOM_BASE = 30'h1555_5500; // low 6 bits free

    logic                    clk;
    logic                    proc_reset;
    logic                    proc_read;
    icache_pkg::word_addr_t  proc_addr;
    logic                    proc_stall;
    icache_pkg::word_t       proc_rdata;
    logic                    mem_read;
    icache_pkg::block_addr_t mem_addr;
    icache_pkg::block_t      mem_rdata;
    logic                    mem_ready;
    logic [31:0]             lcg_state;

    // expected cache contents for the random run
    logic             model_valid [`ICACHE_LINES][`ICACHE_WAYS];
    icache_pkg::tag_t model_tag   [`ICACHE_LINES][`ICACHE_WAYS];
    logic             model_lru   [`ICACHE_LINES];

    icache_top dut_i (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read_i  (proc_read),
        .proc_addr_i  (proc_addr),
        .proc_stall_o (proc_stall),
        .proc_rdata_o (proc_rdata),
        .mem_read_o   (mem_read),
        .mem_addr_o   (mem_addr),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    tb_mem_model u_mem (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .mem_read_i  (mem_read),
        .mem_addr_i  (mem_addr),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s expected 0x%h, got 0x%h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // word address times 3 plus a fixed offset
    function automatic logic [31:0] expected_word(input icache_pkg::word_addr_t addr);
        return 32'(addr) * 32'd3 + 32'h5A00_0000;
    endfunction

    function automatic icache_pkg::word_addr_t make_addr(input icache_pkg::tag_t tag,
            input icache_pkg::index_t index, input icache_pkg::offset_t offset);
        return {tag, index, offset};
    endfunction

    // updates the model and returns whether the read should miss
    function automatic logic predict_miss(input icache_pkg::word_addr_t addr);
        icache_pkg::tag_t   tag;
        icache_pkg::index_t index;
        int                 way;
        tag   = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        index = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        way   = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[index][w] && model_tag[index][w] == tag) begin
                way = w;
            end
        end
        predict_miss = (way < 0);
        if (way < 0) begin
            way = model_lru[index]; // least recently used way gets the block
            model_valid[index][way] = 1'b1;
            model_tag[index][way]   = tag;
        end
        model_lru[index] = (way == 0);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        proc_reset <= 1'b1;
        proc_read  <= 1'b0;
        repeat (8) @(posedge clk);
        proc_reset <= 1'b0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            model_lru[i] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[i][w] = 1'b0;
            end
        end
    endtask

    // one read checked cycle by cycle at the falling edge
    task automatic read_word(input icache_pkg::word_addr_t addr, input logic expect_miss);
        int waited;
        @(posedge clk);
        proc_read <= 1'b1;
        proc_addr <= addr;
        @(negedge clk);
        check_value("proc_stall_o", expect_miss, proc_stall);
        check_value("mem_read_o", expect_miss, mem_read);
        if (expect_miss) begin
            waited = 0;
            while (!mem_ready) begin
                check_value("mem_read_o", 1'b1, mem_read);
                check_value("mem_addr_o", addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], mem_addr);
                check_value("proc_stall_o", 1'b1, proc_stall);
                if (waited == WAIT_LIMIT) begin
                    fail_run($sformatf("Timeout: no mem_ready_i within %0d cycles", waited));
                end
                @(negedge clk);
                waited++;
            end
            // request drops in the ready cycle and stall lasts one more
            check_value("mem_read_o", 1'b0, mem_read);
            check_value("proc_stall_o", 1'b1, proc_stall);
            @(negedge clk);
            check_value("proc_stall_o", 1'b0, proc_stall);
            check_value("mem_read_o", 1'b0, mem_read);
        end
        check_value("proc_rdata_o", expected_word(addr), proc_rdata);
    endtask

    task automatic test_first_miss();
        read_word(make_addr(26'h12345, 2'd1, 2'd2), 1'b1);
    endtask

    task automatic test_block_hits();
        for (int off = 0; off < 4; off++) begin
            read_word(make_addr(26'h12345, 2'd1, off[1:0]), 1'b0);
        end
    endtask

    task automatic test_two_ways();
        read_word(make_addr(26'h100, 2'd2, 2'd0), 1'b1);
        read_word(make_addr(26'h200, 2'd2, 2'd1), 1'b1);
        read_word(make_addr(26'h100, 2'd2, 2'd3), 1'b0);
        read_word(make_addr(26'h200, 2'd2, 2'd0), 1'b0);
    endtask

    task automatic test_lru();
        read_word(make_addr(26'h0AA, 2'd3, 2'd0), 1'b1); // A
        read_word(make_addr(26'h0BB, 2'd3, 2'd0), 1'b1); // B
        read_word(make_addr(26'h0AA, 2'd3, 2'd1), 1'b0); // A most recent
        read_word(make_addr(26'h0CC, 2'd3, 2'd2), 1'b1); // C evicts B
        read_word(make_addr(26'h0AA, 2'd3, 2'd3), 1'b0);
        read_word(make_addr(26'h0BB, 2'd3, 2'd1), 1'b1);
    endtask

    // four tags per index over two ways keeps evictions frequent
    task automatic test_random();
        icache_pkg::word_addr_t addr;
        apply_reset();
        repeat (RANDOM_READS) begin
            addr = RANDOM_BASE | icache_pkg::word_addr_t'((next_rand() >> 16) & 32'h3F);
            read_word(addr, predict_miss(addr));
        end
    endtask

    initial begin
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_addr  = '0;
        lcg_state  = 32'd33;
        apply_reset();
        test_first_miss();
        test_block_hits();
        test_two_ways();
        test_lru();
        test_random();
        @(posedge clk);
        proc_read <= 1'b0;
        @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_defs.svh"

module tb_mem_model (
    input  wire                      clk,
    input  wire                      proc_reset,
    input  wire                      mem_read_i,
    input  icache_pkg::block_addr_t  mem_addr_i,
    output icache_pkg::block_t       mem_rdata_o,
    output logic                     mem_ready_o
);

    logic [31:0]             seed;
    logic                    busy;
    int unsigned             wait_left;  // cycles before ready
    icache_pkg::block_addr_t req_addr;

    // latency of 1 to 6 cycles
    function automatic int unsigned next_latency();
        seed = seed * 32'd1103515245 + 32'd12345;
        return 1 + ((seed >> 16) % 6);
    endfunction

    // word k of block b sits at word address b*4 + k
    function automatic icache_pkg::block_t block_data(input icache_pkg::block_addr_t blk);
        icache_pkg::block_t data;
        logic [31:0]        word_addr;
        for (int k = 0; k < `ICACHE_BLOCK_W / `ICACHE_WORD_W; k++) begin
            word_addr = {2'b00, blk, 2'b00} + k;
            data[k*`ICACHE_WORD_W +: `ICACHE_WORD_W] = word_addr * 32'd3 + 32'h5A00_0000;
        end
        return data;
    endfunction

    initial begin
        seed        = 32'd33;
        busy        = 1'b0;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            busy        <= 1'b0;
            mem_ready_o <= 1'b0;
        end else begin
            mem_ready_o <= 1'b0; // ready is a single pulse
            if (busy) begin
                if (wait_left == 0) begin
                    mem_ready_o <= 1'b1;
                    mem_rdata_o <= block_data(req_addr);
                    busy        <= 1'b0;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (mem_read_i) begin
                busy      <= 1'b1;
                wait_left <= next_latency() - 1;
                req_addr  <= mem_addr_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
icache_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv
